// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_serial_bridge
RTL_TOP    := serial_bridge
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully
FAIL_MSG   := Simulation failed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+hw
hw/bridge_pkg.sv
hw/payload_fifo.sv
hw/tx_serializer.sv
hw/gap_timer.sv
hw/rx_packer.sv
hw/serial_bridge.sv
sim/tb_serial_bridge.sv

// ==== hw/bridge_cfg.svh ====
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Bus side
`define BB_BUS_WIDTH       64
`define BB_ADDR_WIDTH      16

// Channel decode on the top address bits
`define BB_CHANNEL_WIDTH   2
`define BB_CHANNEL_ID      2

// Device side, one byte per strobe
`define BB_BYTE_WIDTH      8
`define BB_BYTES_PER_WORD  8

// Data bytes in one receive block, count byte not included
`define BB_BLOCK_BYTES     3

// Queue depths in entries
`define BB_TX_DEPTH        4
`define BB_RX_DEPTH        8

// Idle cycles before an open block is closed
`define BB_GAP_CYCLES      16

`endif

// ==== hw/bridge_pkg.sv ====
`default_nettype none

`include "bridge_cfg.svh"

package bridge_pkg;

    // One bus word, as written by the bus
    typedef logic [`BB_BUS_WIDTH-1:0] bus_word_t;

    // One device byte
    typedef logic [`BB_BYTE_WIDTH-1:0] dev_byte_t;

    // Byte position inside a bus word
    typedef logic [$clog2(`BB_BYTES_PER_WORD)-1:0] byte_index_t;

    // Receive block, data slots above the count byte
    // Slot 0 at 15:8, slot 1 at 23:16, slot 2 at 31:24
    typedef logic [`BB_BYTE_WIDTH*(`BB_BLOCK_BYTES+1)-1:0] rx_block_t;

    // Packer FSM states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        COLLECT = 2'd1,
        CLOSE   = 2'd2
    } rx_state_t;

endpackage

`default_nettype wire

// ==== hw/gap_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module gap_timer #(
    parameter int LIMIT = 16
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic enable,
    input  wire logic clear,
    output logic      expired
);

    localparam int CNT_W = $clog2(LIMIT + 1);

    // Idle cycles seen since the last clear
    logic [CNT_W-1:0] count;

    // Sticky at the limit until cleared
    assign expired = (count == CNT_W'(LIMIT));

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            count <= '0;
        end else if (enable && !expired) begin
            // Saturates at the limit instead of wrapping
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/payload_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module payload_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic push,
    input  payload_t  push_data,
    input  wire logic pop,
    output payload_t  front,
    output logic      full,
    output logic      empty
);

    // Pointer wide enough for any depth, at least one bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Front entry always visible, first word falls through
    assign front = mem[rd_ptr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Pointers wrap at DEPTH, so odd depths work too
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy only moves on a lone push or a lone pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Producer must honour full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full));

    // Consumer must honour empty
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty));

endmodule

`default_nettype wire

// ==== hw/rx_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bridge_cfg.svh"

module rx_packer
    import bridge_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  dev_byte_t device_data_in,
    input  wire logic device_rd_available,
    output logic      device_rd_ins,
    output rx_block_t block,
    output logic      block_push,
    input  wire logic queue_full
);

    rx_state_t state;

    // Block under construction, count in the low byte
    rx_block_t block_q;
    dev_byte_t fill;

    logic take;
    logic last_byte;
    logic timer_en;
    logic timer_clr;
    logic timer_expired;

    assign fill = block_q[`BB_BYTE_WIDTH-1:0];

    // Only take bytes while a block has room
    assign take          = device_rd_available && (state == IDLE || state == COLLECT);
    assign device_rd_ins = take;

    // This byte fills the last slot
    assign last_byte = (fill == dev_byte_t'(`BB_BLOCK_BYTES - 1));

    // Closed block is offered until the queue has space
    assign block      = block_q;
    assign block_push = (state == CLOSE) && !queue_full;

    // Count silence only inside an open block
    assign timer_en  = (state == COLLECT) && !device_rd_available;
    assign timer_clr = take || (state == CLOSE);

    gap_timer #(
        .LIMIT (`BB_GAP_CYCLES)
    ) gap0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (timer_en),
        .clear   (timer_clr),
        .expired (timer_expired)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            block_q <= '0;
        end else begin
            case (state)
                IDLE, COLLECT: begin
                    if (take) begin
                        // Next free slot sits just above the ones filled
                        for (int i = 0; i < `BB_BLOCK_BYTES; i++) begin
                            if (fill == dev_byte_t'(i)) begin
                                block_q[`BB_BYTE_WIDTH*(i+1) +: `BB_BYTE_WIDTH] <=
                                    device_data_in;
                            end
                        end
                        block_q[`BB_BYTE_WIDTH-1:0] <= fill + 1'b1;
                        state <= last_byte ? CLOSE : COLLECT;
                    end else if (state == COLLECT && timer_expired) begin
                        // Partial block after a quiet gap
                        state <= CLOSE;
                    end
                end
                CLOSE: begin
                    // Hold here while the queue is full
                    if (!queue_full) begin
                        block_q <= '0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Slot count stays within the block
    a_fill_max: assert property (@(posedge clk) disable iff (!rst_n)
        fill <= dev_byte_t'(`BB_BLOCK_BYTES));

    // Queue never sees an empty block
    a_push_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        block_push |-> (fill != '0));

endmodule

`default_nettype wire

// ==== hw/serial_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bridge_cfg.svh"

module serial_bridge
    import bridge_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    // Bus side
    input  wire logic [`BB_ADDR_WIDTH-1:0] addr,
    input  wire logic                      wr_req,
    input  bus_word_t                      wr_data,
    input  wire logic                      rd_req,
    output logic                           wr_avail,
    output logic                           rd_valid,
    output bus_word_t                      rd_data,
    // Device side
    output dev_byte_t                      device_data_out,
    output logic                           device_wr_ins,
    input  wire logic                      device_wr_available,
    input  dev_byte_t                      device_data_in,
    output logic                           device_rd_ins,
    input  wire logic                      device_rd_available
);

    logic      selected;

    logic      tx_push;
    logic      tx_pop;
    logic      tx_full;
    logic      tx_empty;
    bus_word_t tx_front;

    logic      rx_push;
    logic      rx_pop;
    logic      rx_full;
    logic      rx_empty;
    rx_block_t rx_block;
    rx_block_t rx_front;

    // Channel decode on the top address bits
    assign selected = (addr[`BB_ADDR_WIDTH-1 -: `BB_CHANNEL_WIDTH] ==
                       `BB_CHANNEL_WIDTH'(`BB_CHANNEL_ID));

    // Status reads zero when another channel is addressed
    assign wr_avail = selected && !tx_full;
    assign rd_valid = selected && !rx_empty;

    // Strobes only count when the bridge can act on them
    assign tx_push = wr_req && wr_avail;
    assign rx_pop  = rd_req && rd_valid;

    // Front block zero-extended into the bus word
    assign rd_data = rd_valid ?
                     {{(`BB_BUS_WIDTH - $bits(rx_block_t)){1'b0}}, rx_front} : '0;

    // Transmit queue of whole bus words
    payload_fifo #(
        .payload_t (bus_word_t),
        .DEPTH     (`BB_TX_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (wr_data),
        .pop       (tx_pop),
        .front     (tx_front),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    tx_serializer tx0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .word                (tx_front),
        .word_ready          (!tx_empty),
        .device_wr_available (device_wr_available),
        .device_data_out     (device_data_out),
        .device_wr_ins       (device_wr_ins),
        .word_done           (tx_pop)
    );

    rx_packer rx0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .device_data_in      (device_data_in),
        .device_rd_available (device_rd_available),
        .device_rd_ins       (device_rd_ins),
        .block               (rx_block),
        .block_push          (rx_push),
        .queue_full          (rx_full)
    );

    // Receive queue of closed blocks
    payload_fifo #(
        .payload_t (rx_block_t),
        .DEPTH     (`BB_RX_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_block),
        .pop       (rx_pop),
        .front     (rx_front),
        .full      (rx_full),
        .empty     (rx_empty)
    );

endmodule

`default_nettype wire

// ==== hw/tx_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bridge_cfg.svh"

module tx_serializer
    import bridge_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  bus_word_t word,
    input  wire logic word_ready,
    input  wire logic device_wr_available,
    output dev_byte_t device_data_out,
    output logic      device_wr_ins,
    output logic      word_done
);

    localparam byte_index_t LAST_POS = byte_index_t'(`BB_BYTES_PER_WORD - 1);

    // Next byte of the front word to send
    byte_index_t pos;

    // Byte mux with the lowest byte first
    assign device_data_out = word[`BB_BYTE_WIDTH*pos +: `BB_BYTE_WIDTH];

    // One byte per cycle while a word waits and the device takes it
    assign device_wr_ins = word_ready && device_wr_available;

    // Eighth strobe retires the word
    assign word_done = device_wr_ins && (pos == LAST_POS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (device_wr_ins) begin
            // Back to byte 0 for the next word
            if (word_done) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
        // Position simply holds while the device stalls
    end

    // Device must never see a strobe it cannot take
    a_strobe_avail: assert property (@(posedge clk) disable iff (!rst_n)
        device_wr_ins |-> device_wr_available);

endmodule

`default_nettype wire

// ==== sim/tb_serial_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bridge_cfg.svh"

module tb_serial_bridge
    import bridge_pkg::*;
();

    // Channel 2 in the top two address bits
    localparam logic [15:0] CH_ADDR    = 16'h8000;
    // Channel 1 for the miss case
    localparam logic [15:0] OTHER_ADDR = 16'h4000;

    // Rough cycle budget per test with reset first
    localparam int RUN_CYCLES = 8 + 40 + 50 + 80 + 60 + (`BB_GAP_CYCLES + 40) + 200;

    logic                      clk;
    logic                      rst_n;
    logic [`BB_ADDR_WIDTH-1:0] addr;
    logic                      wr_req;
    bus_word_t                 wr_data;
    logic                      rd_req;
    logic                      wr_avail;
    logic                      rd_valid;
    bus_word_t                 rd_data;
    dev_byte_t                 device_data_out;
    logic                      device_wr_ins;
    logic                      device_wr_available;
    dev_byte_t                 device_data_in;
    logic                      device_rd_ins;
    logic                      device_rd_available;

    integer    seed;
    int        errors;
    int        checks;
    int        rd_ins_count;
    logic      rd_taken;
    dev_byte_t dev_q[$];
    dev_byte_t rx_expect[$];
    dev_byte_t tx_log[$];
    dev_byte_t tx_expect[$];

    serial_bridge dut0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .addr                (addr),
        .wr_req              (wr_req),
        .wr_data             (wr_data),
        .rd_req              (rd_req),
        .wr_avail            (wr_avail),
        .rd_valid            (rd_valid),
        .rd_data             (rd_data),
        .device_data_out     (device_data_out),
        .device_wr_ins       (device_wr_ins),
        .device_wr_available (device_wr_available),
        .device_data_in      (device_data_in),
        .device_rd_ins       (device_rd_ins),
        .device_rd_available (device_rd_available)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Strobes as seen just before each edge
    always @(posedge clk) begin
        rd_taken <= device_rd_ins;
        if (device_rd_ins) begin
            rd_ins_count <= rd_ins_count + 1;
        end
        if (device_wr_ins) begin
            tx_log.push_back(device_data_out);
        end
    end

    // Device model drops a byte once the bridge has taken it
    initial begin : device_model
        dev_byte_t dropped;
        device_rd_available = 1'b0;
        device_data_in      = '0;
        forever begin
            @(negedge clk);
            if (rd_taken === 1'b1 && dev_q.size() != 0) begin
                dropped = dev_q.pop_front();
            end
            device_rd_available = (dev_q.size() != 0);
            device_data_in      = (dev_q.size() != 0) ? dev_q[0] : '0;
        end
    end

    task automatic expect_eq(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic wait_rd_valid(input int limit);
        int n;
        n = 0;
        while (!rd_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!rd_valid) begin
            report_failure("rd_valid did not rise in time");
        end
    endtask

    task automatic wait_tx_bytes(input int count, input int limit);
        int n;
        n = 0;
        while (tx_log.size() < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (tx_log.size() < count) begin
            report_failure("device strobes stopped before all bytes came out");
        end
    endtask

    task automatic bus_write(input bus_word_t w);
        wr_data = w;
        wr_req  = 1'b1;
        @(negedge clk);
        wr_req  = 1'b0;
    endtask

    task automatic read_block(output bus_word_t got);
        got    = rd_data;
        rd_req = 1'b1;
        @(negedge clk);
        rd_req = 1'b0;
    endtask

    // Lowest byte of the word goes out first
    task automatic queue_word(input bus_word_t w);
        for (int i = 0; i < `BB_BYTES_PER_WORD; i++) begin
            tx_expect.push_back(w[8*i +: 8]);
        end
    endtask

    // Bytes handed over between falling edges
    task automatic offer_bytes(input int n);
        dev_byte_t b;
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            b = dev_byte_t'($random(seed));
            dev_q.push_back(b);
            rx_expect.push_back(b);
        end
        @(negedge clk);
    endtask

    task automatic compare_tx();
        int n;
        n = tx_expect.size();
        wait_tx_bytes(n, 20 * n + 20);
        // Stray strobes would land here
        repeat (20) @(negedge clk);
        expect_eq("device_wr_ins byte count", 64'(tx_log.size()), 64'(n));
        for (int i = 0; i < n && i < tx_log.size(); i++) begin
            expect_eq("device_data_out", 64'(tx_log[i]), 64'(tx_expect[i]));
        end
        tx_log.delete();
        tx_expect.delete();
    endtask

    // Slot i at bits 8*(i+1) above the count byte with zeros on top
    task automatic check_block(input bus_word_t got);
        int cnt;
        cnt = int'(got[7:0]);
        if (cnt < 1 || cnt > `BB_BLOCK_BYTES) begin
            report_failure("receive block count out of range");
            cnt = 0;
        end
        for (int i = 0; i < cnt; i++) begin
            if (rx_expect.size() == 0) begin
                report_failure("block holds more bytes than the device sent");
            end else begin
                expect_eq("rd_data slot", 64'(got[8*(i+1) +: 8]), 64'(rx_expect.pop_front()));
            end
        end
        expect_eq("rd_data unused bits", got >> (8 * (cnt + 1)), 64'h0);
    endtask

    task automatic test_single_write();
        bus_word_t w;
        device_wr_available = 1'b1;
        w = {$random(seed), $random(seed)};
        expect_eq("wr_avail", 64'(wr_avail), 64'h1);
        queue_word(w);
        bus_write(w);
        compare_tx();
    endtask

    task automatic test_other_channel();
        bus_word_t got;
        // Park one block in the receive queue first
        offer_bytes(`BB_BLOCK_BYTES);
        wait_rd_valid(50);
        addr = OTHER_ADDR;
        @(negedge clk);
        expect_eq("wr_avail", 64'(wr_avail), 64'h0);
        expect_eq("rd_valid", 64'(rd_valid), 64'h0);
        // Neither strobe may reach the queues
        bus_write({$random(seed), $random(seed)});
        read_block(got);
        expect_eq("rd_data", got, 64'h0);
        repeat (20) @(negedge clk);
        expect_eq("device_wr_ins byte count", 64'(tx_log.size()), 64'h0);
        addr = CH_ADDR;
        @(negedge clk);
        // Parked block is still there once selected again
        expect_eq("rd_valid", 64'(rd_valid), 64'h1);
        read_block(got);
        check_block(got);
    endtask

    task automatic test_tx_backpressure();
        bus_word_t w;
        device_wr_available = 1'b0;
        for (int i = 0; i < `BB_TX_DEPTH; i++) begin
            w = {$random(seed), $random(seed)};
            queue_word(w);
            bus_write(w);
        end
        expect_eq("wr_avail", 64'(wr_avail), 64'h0);
        expect_eq("device_wr_ins byte count", 64'(tx_log.size()), 64'h0);
        // Fifth word meets a full queue and is lost
        bus_write({$random(seed), $random(seed)});
        device_wr_available = 1'b1;
        compare_tx();
    endtask

    task automatic test_full_blocks();
        bus_word_t got;
        offer_bytes(2 * `BB_BLOCK_BYTES);
        for (int k = 0; k < 2; k++) begin
            wait_rd_valid(50);
            read_block(got);
            expect_eq("rd_data count", 64'(got[7:0]), 64'(`BB_BLOCK_BYTES));
            check_block(got);
        end
    endtask

    task automatic test_gap_block();
        bus_word_t got;
        offer_bytes(1);
        wait_rd_valid(`BB_GAP_CYCLES + 30);
        read_block(got);
        expect_eq("rd_data count", 64'(got[7:0]), 64'h1);
        check_block(got);
        expect_eq("rd_valid", 64'(rd_valid), 64'h0);
    endtask

    task automatic test_rx_backpressure();
        bus_word_t got;
        int pulses;
        offer_bytes(30);
        // Queue and packer fill before the device stalls
        repeat (80) @(negedge clk);
        pulses = rd_ins_count;
        repeat (10) @(negedge clk);
        expect_eq("device_rd_ins pulses while full", 64'(rd_ins_count - pulses), 64'h0);
        if (dev_q.size() == 0) begin
            report_failure("device ran out of bytes before the queue filled");
        end
        while (rx_expect.size() > 0) begin
            wait_rd_valid(60);
            if (!rd_valid) begin
                break;
            end
            read_block(got);
            check_block(got);
        end
        expect_eq("device bytes left", 64'(dev_q.size()), 64'h0);
    endtask

    initial begin
        seed                = 47;
        errors              = 0;
        checks              = 0;
        rst_n               = 1'b0;
        addr                = OTHER_ADDR;
        wr_req              = 1'b0;
        wr_data             = '0;
        rd_req              = 1'b0;
        device_wr_available = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // Quiet outputs straight after reset
        expect_eq("device_wr_ins", 64'(device_wr_ins), 64'h0);
        expect_eq("wr_avail", 64'(wr_avail), 64'h0);
        addr = CH_ADDR;
        @(negedge clk);
        // Nothing queued yet on the selected channel
        expect_eq("rd_valid", 64'(rd_valid), 64'h0);
        test_single_write();
        test_other_channel();
        test_tx_backpressure();
        test_full_blocks();
        test_gap_block();
        test_rx_backpressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Backstop at twice the summed test budget
    initial begin : watchdog
        repeat (2 * RUN_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", 2 * RUN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
